// File: hw/bridge_pkg.sv
/*
 * bridge bus request type, register map and
 * control/status layouts of the trace recorder
 */

package bridge_pkg;

  // one bridge bus cycle, synchronous to clk_74a
  typedef struct packed {
    logic [31:0] addr;
    logic        rd;
    logic        wr;
    logic [31:0] wr_data;
  } bridge_req_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map

  // write arms with skip count in [15:0], read returns last skip count
  localparam logic [31:0] REG_TRACE_CTRL = 32'h0000_0100;

  // read only, state in [1:0], fill count in [12:8]
  localparam logic [31:0] REG_TRACE_STATUS = 32'h0000_0104;

  ////////////////////////////////////////////////////////////////////////////
  // register layouts

  typedef struct packed {
    logic        arm;
    logic [15:0] skip;
  } trace_ctrl_t;

  typedef struct packed {
    trace_pkg::trace_state_e state;
    trace_pkg::trace_count_t count;
  } trace_status_t;

endpackage

// File: hw/bridge_regs.sv
/*
 * bridge register block
 * arm command from control writes, read data mux
 */

`timescale 1ns/1ps

module bridge_regs (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,
  input  bridge_pkg::bridge_req_t   bridge,
  input  bridge_pkg::trace_status_t status,
  output bridge_pkg::trace_ctrl_t   ctrl,
  output logic [31:0]               rd_data
);

  logic ctrl_wr;

  assign ctrl_wr = bridge.wr && (bridge.addr == bridge_pkg::REG_TRACE_CTRL);

  // writes are always accepted, arm lasts one cycle
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ctrl.arm  <= 1'b0;
      ctrl.skip <= '0;
    end else begin
      ctrl.arm <= ctrl_wr;
      if (ctrl_wr) begin
        ctrl.skip <= bridge.wr_data[15:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux, no wait states

  always_comb begin
    case (bridge.addr)
      bridge_pkg::REG_TRACE_CTRL: begin
        rd_data = {16'h0000, ctrl.skip};
      end
      bridge_pkg::REG_TRACE_STATUS: begin
        // count in [12:8], state in [1:0]
        rd_data = {19'd0, status.count, 6'd0, status.state};
      end
      default: begin
        rd_data = 32'h0000_0000;
      end
    endcase
  end

endmodule

// File: hw/pc_capture.sv
/*
 * program counter change detector
 * counts off skipped changes after arm, then strobes each new value
 */

`timescale 1ns/1ps

module pc_capture (
  input  logic                    clk_74a,
  input  logic                    pll_core_locked,
  input  trace_pkg::pc_t          debug_pc,
  input  bridge_pkg::trace_ctrl_t ctrl,
  input  logic                    capturing,
  output logic                    cap_valid,
  output trace_pkg::pc_t          cap_pc
);

  trace_pkg::pc_t prev_pc;
  logic [15:0]    skip_left;
  logic           strobe;
  logic           pc_changed;

  assign pc_changed = (debug_pc != prev_pc);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_pc   <= '0;
      skip_left <= '0;
      strobe    <= 1'b0;
    end else begin
      prev_pc <= debug_pc;
      strobe  <= 1'b0;
      if (ctrl.arm) begin
        skip_left <= ctrl.skip;
      end else if (capturing && pc_changed) begin
        // skipped changes are consumed first
        if (skip_left != 16'd0) begin
          skip_left <= skip_left - 16'd1;
        end else begin
          strobe <= 1'b1;
        end
      end
    end
  end

  // value only moves on a change, so it holds with the strobe
  always_ff @(posedge clk_74a) begin
    if (pc_changed) begin
      cap_pc <= debug_pc;
    end
  end

  // a strobe that lands as the buffer fills is dropped here
  assign cap_valid = strobe & capturing;

endmodule

// File: hw/pc_trace_top.sv
/*
 * program counter trace recorder top level
 * bridge registers, capture, buffer, serializer and UART
 */

`timescale 1ns/1ps

module pc_trace_top (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  bridge_pkg::bridge_req_t bridge,
  output logic [31:0]            bridge_rd_data,
  input  trace_pkg::pc_t         debug_pc,
  output logic                   uart_txd
);

  bridge_pkg::trace_ctrl_t   ctrl;
  bridge_pkg::trace_status_t status;

  logic           capturing;
  logic           cap_valid;
  trace_pkg::pc_t cap_pc;

  logic           word_valid;
  logic           word_ready;
  trace_pkg::pc_t word;

  logic       tx_valid;
  logic [7:0] tx_byte;
  logic       tx_busy;

  bridge_regs bridge_regs_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .status          (status),
    .ctrl            (ctrl),
    .rd_data         (bridge_rd_data)
  );

  pc_capture pc_capture_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .debug_pc        (debug_pc),
    .ctrl            (ctrl),
    .capturing       (capturing),
    .cap_valid       (cap_valid),
    .cap_pc          (cap_pc)
  );

  trace_buffer trace_buffer_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .ctrl            (ctrl),
    .cap_valid       (cap_valid),
    .cap_pc          (cap_pc),
    .capturing       (capturing),
    .status          (status),
    .word_valid      (word_valid),
    .word            (word),
    .word_ready      (word_ready)
  );

  trace_serializer trace_serializer_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .word_valid      (word_valid),
    .word            (word),
    .word_ready      (word_ready),
    .tx_valid        (tx_valid),
    .tx_byte         (tx_byte),
    .tx_busy         (tx_busy)
  );

  uart_tx uart_tx_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .tx_valid        (tx_valid),
    .tx_byte         (tx_byte),
    .tx_busy         (tx_busy),
    .txd             (uart_txd)
  );

endmodule

// File: hw/trace_buffer.sv
/*
 * trace memory with a shared write/read address counter
 * and the idle/capture/dump/done recorder FSM
 */

`timescale 1ns/1ps

module trace_buffer (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,
  input  bridge_pkg::trace_ctrl_t   ctrl,
  input  logic                      cap_valid,
  input  trace_pkg::pc_t            cap_pc,
  output logic                      capturing,
  output bridge_pkg::trace_status_t status,
  output logic                      word_valid,
  output trace_pkg::pc_t            word,
  input  logic                      word_ready
);

  trace_pkg::pc_t          mem [trace_pkg::TRACE_DEPTH];
  trace_pkg::trace_state_e state;
  trace_pkg::trace_addr_t  addr;
  trace_pkg::trace_count_t count;
  logic                    last_addr;

  assign last_addr = (addr == trace_pkg::trace_addr_t'(trace_pkg::TRACE_DEPTH - 1));

  ////////////////////////////////////////////////////////////////////////////
  // recorder FSM

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state      <= trace_pkg::IDLE;
      addr       <= '0;
      count      <= '0;
      word_valid <= 1'b0;
    end else if (ctrl.arm) begin
      state      <= trace_pkg::CAPTURE;
      addr       <= '0;
      count      <= '0;
      word_valid <= 1'b0;
    end else begin
      case (state)
        trace_pkg::CAPTURE: begin
          if (cap_valid) begin
            // wraps back to entry 0 on the last write, ready for the dump
            addr  <= addr + 1'b1;
            count <= count + 1'b1;
            if (last_addr) begin
              state <= trace_pkg::DUMP;
            end
          end
        end
        trace_pkg::DUMP: begin
          if (!word_valid) begin
            word_valid <= 1'b1;
          end else if (word_ready) begin
            word_valid <= 1'b0;
            if (last_addr) begin
              state <= trace_pkg::DONE;
            end else begin
              addr <= addr + 1'b1;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory, one cycle read into the output word

  always_ff @(posedge clk_74a) begin
    if (state == trace_pkg::CAPTURE && cap_valid) begin
      mem[addr] <= cap_pc;
    end
  end

  // loads only while no word is offered, so it holds until taken
  always_ff @(posedge clk_74a) begin
    if (state == trace_pkg::DUMP && !word_valid) begin
      word <= mem[addr];
    end
  end

  assign capturing    = (state == trace_pkg::CAPTURE);
  assign status.state = state;
  assign status.count = count;

endmodule

// File: hw/trace_pkg.sv
/*
 * trace recorder types and constants
 * program counter type, buffer depth and index types,
 * recorder state encoding, UART bit timing
 */

package trace_pkg;

  // program counter as seen on the debug port
  typedef logic [23:0] pc_t;

  ////////////////////////////////////////////////////////////////////////////
  // trace buffer sizing

  localparam int TRACE_DEPTH = 16;

  typedef logic [$clog2(TRACE_DEPTH)-1:0] trace_addr_t;

  // one extra bit so a full buffer reads as TRACE_DEPTH
  typedef logic [$clog2(TRACE_DEPTH):0] trace_count_t;

  ////////////////////////////////////////////////////////////////////////////
  // recorder state, also visible in the status register

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    CAPTURE = 2'd1,
    DUMP    = 2'd2,
    DONE    = 2'd3
  } trace_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // UART replay

  // bit period in clk_74a cycles
  localparam int CLKS_PER_BIT = 24;

  // msb first, one entry per three bytes
  localparam int BYTES_PER_ENTRY = 3;

endpackage

// File: hw/trace_serializer.sv
/*
 * entry to byte serializer
 * three bytes per entry, msb first, paced by the UART busy flag
 */

`timescale 1ns/1ps

module trace_serializer (
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  logic           word_valid,
  input  trace_pkg::pc_t word,
  output logic           word_ready,
  output logic           tx_valid,
  output logic [7:0]     tx_byte,
  input  logic           tx_busy
);

  trace_pkg::pc_t shift_q;
  logic [1:0]     bytes_left;
  logic           word_take;
  logic           byte_take;

  assign word_ready = (bytes_left == 2'd0);
  assign word_take  = word_valid && word_ready;

  assign tx_valid  = (bytes_left != 2'd0);
  assign tx_byte   = shift_q[23:16];
  assign byte_take = tx_valid && !tx_busy;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      bytes_left <= 2'd0;
    end else if (word_take) begin
      bytes_left <= 2'(trace_pkg::BYTES_PER_ENTRY);
    end else if (byte_take) begin
      bytes_left <= bytes_left - 2'd1;
    end
  end

  // next byte moves up into [23:16] once the UART takes one
  always_ff @(posedge clk_74a) begin
    if (word_take) begin
      shift_q <= word;
    end else if (byte_take) begin
      shift_q <= {shift_q[15:0], 8'h00};
    end
  end

endmodule

// File: hw/uart_tx.sv
/*
 * 8N1 UART transmitter, fixed bit period, lsb first
 */

`timescale 1ns/1ps

module uart_tx (
  input  logic       clk_74a,
  input  logic       pll_core_locked,
  input  logic       tx_valid,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       txd
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  tx_state_e state;
  logic [$clog2(trace_pkg::CLKS_PER_BIT)-1:0] clk_cnt;
  logic [2:0] bit_idx;
  logic [7:0] data_q;
  logic       bit_end;

  assign bit_end = (clk_cnt == ($bits(clk_cnt))'(trace_pkg::CLKS_PER_BIT - 1));

  // high from the cycle after a byte is taken through the stop bit
  assign tx_busy = (state != TX_IDLE);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          clk_cnt <= '0;
          if (tx_valid) begin
            txd   <= 1'b0;
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            txd     <= data_q[0];
            bit_idx <= '0;
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            if (bit_idx == 3'd7) begin
              txd   <= 1'b1;
              state <= TX_STOP;
            end else begin
              txd     <= data_q[bit_idx + 3'd1];
              bit_idx <= bit_idx + 3'd1;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= TX_IDLE;
          end
        end
      endcase
    end
  end

  // byte held for the whole frame
  always_ff @(posedge clk_74a) begin
    if (state == TX_IDLE && tx_valid) begin
      data_q <= tx_byte;
    end
  end

endmodule

// File: list.f
hw/trace_pkg.sv
hw/bridge_pkg.sv
hw/bridge_regs.sv
hw/pc_capture.sv
hw/trace_buffer.sv
hw/trace_serializer.sv
hw/uart_tx.sv
hw/pc_trace_top.sv
tests/pc_trace_sva.sv
tests/pc_trace_tb.sv

// File: tests/pc_trace_sva.sv
/*
 * handshake and reset assertions for the trace buffer
 * and the serializer, attached by bind
 */

`timescale 1ns/1ps

module pc_trace_sva (
  input logic                    clk_74a,
  input logic                    pll_core_locked,
  input logic                    valid,
  input trace_pkg::pc_t          data,
  input logic                    ready,
  input logic                    cap_valid,
  input logic                    capturing,
  input trace_pkg::trace_count_t count,
  input trace_pkg::trace_state_e state
);

  // offered data holds until it is taken
  hold_until_taken_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    valid && !ready |=> valid && $stable(data))
    else $error("valid or data changed before ready");

  // strobes land only while capturing with room left
  cap_in_capture_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    cap_valid |-> capturing && count < trace_pkg::TRACE_DEPTH)
    else $error("cap_valid seen outside CAPTURE or with the buffer full");

  // first cycle out of reset
  reset_idle_a: assert property (@(posedge clk_74a)
    $rose(pll_core_locked) |-> state == trace_pkg::IDLE && !valid)
    else $error("recorder not idle right after reset");

endmodule

bind trace_buffer pc_trace_sva trace_buffer_sva_inst (
  .clk_74a         (clk_74a),
  .pll_core_locked (pll_core_locked),
  .valid           (word_valid),
  .data            (word),
  .ready           (word_ready),
  .cap_valid       (cap_valid),
  .capturing       (capturing),
  .count           (count),
  .state           (state)
);

// serializer side toward the UART, busy is the back-pressure
bind trace_serializer pc_trace_sva trace_serializer_sva_inst (
  .clk_74a         (clk_74a),
  .pll_core_locked (pll_core_locked),
  .valid           (tx_valid),
  .data            ({16'h0000, tx_byte}),
  .ready           (!tx_busy),
  .cap_valid       (1'b0),
  .capturing       (1'b0),
  .count           ('0),
  .state           (trace_pkg::IDLE)
);

// File: tests/pc_trace_tb.sv
/*
 * testbench for the program counter trace recorder
 * clock and reset, random program counter stimulus, bridge tasks,
 * UART decoder, trace model and compare tasks
 */

`timescale 1ns/1ps

module pc_trace_tb;

  localparam int START_TIMEOUT = 4000;
  localparam int STATE_TIMEOUT = 500;

  logic                    clk_74a;
  logic                    pll_core_locked;
  bridge_pkg::bridge_req_t bridge;
  logic [31:0]             bridge_rd_data;
  trace_pkg::pc_t          debug_pc;
  logic                    uart_txd;

  integer         seed = 76;
  int             error_count = 0;
  int             failure_count = 0;
  trace_pkg::pc_t model_q[$];
  logic [7:0]     rx_q[$];

  pc_trace_top pc_trace_top_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .bridge_rd_data  (bridge_rd_data),
    .debug_pc        (debug_pc),
    .uart_txd        (uart_txd)
  );

  always #20 clk_74a = ~clk_74a;

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_byte(input logic [7:0] got, input logic [7:0] want, input string msg);
    if (got !== want) begin
      $display("Error at %0t: %s got 0x%02h, expected 0x%02h", $time, msg, got, want);
      error_count++;
    end
  endtask

  task automatic check_status(input bridge_pkg::trace_status_t got,
                              input bridge_pkg::trace_status_t want, input string msg);
    if (got !== want) begin
      $display("Error at %0t: %s got state %0d count %0d, expected state %0d count %0d",
               $time, msg, got.state, got.count, want.state, want.count);
      error_count++;
    end
  endtask

  task automatic check_rd_data(input logic [31:0] got, input logic [31:0] want,
                               input string msg);
    if (got !== want) begin
      $display("Error at %0t: %s got 0x%08h, expected 0x%08h", $time, msg, got, want);
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bridge access

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    #2;
    bridge.addr    = addr;
    bridge.wr_data = data;
    bridge.rd      = 1'b0;
    bridge.wr      = 1'b1;
    @(posedge clk_74a);
    #2;
    bridge.wr = 1'b0;
  endtask

  // read data is combinational, sampled mid cycle
  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk_74a);
    #2;
    bridge.addr = addr;
    bridge.rd   = 1'b1;
    @(negedge clk_74a);
    data = bridge_rd_data;
  endtask

  task automatic read_status(output bridge_pkg::trace_status_t st);
    logic [31:0] value;
    bridge_read(bridge_pkg::REG_TRACE_STATUS, value);
    check_rd_data(value & ~32'h0000_1F03, 32'h0, "status reserved bits");
    st.state = trace_pkg::trace_state_e'(value[1:0]);
    st.count = value[12:8];
  endtask

  task automatic wait_for_state(input trace_pkg::trace_state_e target);
    bridge_pkg::trace_status_t st;
    int waited;
    waited = 0;
    read_status(st);
    while (st.state != target && waited < STATE_TIMEOUT) begin
      read_status(st);
      waited++;
    end
    if (st.state != target) begin
      $display("Timeout: recorder never reached state %0d", target);
      failure_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // program counter stimulus and model

  // each change holds 3 to 6 cycles, status read in the last one
  task automatic drive_changes(input int n, input bit armed, input int skip);
    trace_pkg::pc_t            next_pc;
    bridge_pkg::trace_status_t got;
    bridge_pkg::trace_status_t want;
    int                        hold;
    int                        skipped;
    skipped = 0;
    for (int i = 0; i < n; i++) begin
      next_pc = trace_pkg::pc_t'($random(seed));
      while (next_pc == debug_pc) begin
        next_pc = trace_pkg::pc_t'($random(seed));
      end
      hold = 3 + int'($unsigned($random(seed)) % 4);
      @(posedge clk_74a);
      #2;
      debug_pc = next_pc;
      if (armed && skipped < skip) begin
        skipped++;
      end else if (armed && model_q.size() < trace_pkg::TRACE_DEPTH) begin
        model_q.push_back(next_pc);
      end
      repeat (hold - 2) @(posedge clk_74a);
      read_status(got);
      if (armed) begin
        want.count = trace_pkg::trace_count_t'(model_q.size());
        want.state = (model_q.size() == trace_pkg::TRACE_DEPTH) ? trace_pkg::DUMP
                                                                 : trace_pkg::CAPTURE;
      end else begin
        want.state = trace_pkg::IDLE;
        want.count = '0;
        if (uart_txd !== 1'b1) begin
          $display("UART line left idle while the recorder was not armed");
          failure_count++;
        end
      end
      check_status(got, want, $sformatf("status after change %0d", i));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // UART decoder, samples each bit in its middle

  task automatic receive_byte(output logic [7:0] data, output bit ok);
    int waited;
    waited = 0;
    ok     = 1'b0;
    data   = 8'h00;
    while (uart_txd !== 1'b0 && waited < START_TIMEOUT) begin
      @(negedge clk_74a);
      waited++;
    end
    if (uart_txd !== 1'b0) begin
      $display("Timeout: no UART start bit within %0d cycles", START_TIMEOUT);
      failure_count++;
      return;
    end
    repeat (trace_pkg::CLKS_PER_BIT / 2) @(negedge clk_74a);
    if (uart_txd !== 1'b0) begin
      $display("Framing error: start bit did not stay low at %0t", $time);
      failure_count++;
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (trace_pkg::CLKS_PER_BIT) @(negedge clk_74a);
      data[i] = uart_txd;
    end
    repeat (trace_pkg::CLKS_PER_BIT) @(negedge clk_74a);
    if (uart_txd !== 1'b1) begin
      $display("Framing error: stop bit was low at %0t", $time);
      failure_count++;
      return;
    end
    ok = 1'b1;
  endtask

  task automatic receive_dump(input int n);
    logic [7:0] data;
    bit         ok;
    for (int i = 0; i < n; i++) begin
      receive_byte(data, ok);
      if (!ok) begin
        break;
      end
      rx_q.push_back(data);
    end
  endtask

  // three bytes per entry, msb first
  task automatic compare_dump();
    int n;
    n = trace_pkg::TRACE_DEPTH * trace_pkg::BYTES_PER_ENTRY;
    if (rx_q.size() != n || model_q.size() != trace_pkg::TRACE_DEPTH) begin
      $display("UART sent %0d bytes for %0d recorded changes, expected %0d bytes",
               rx_q.size(), model_q.size(), n);
      failure_count++;
    end
    for (int i = 0; i < rx_q.size() && i / 3 < model_q.size(); i++) begin
      check_byte(rx_q[i], 8'(model_q[i / 3] >> (16 - 8 * (i % 3))),
                 $sformatf("entry %0d byte %0d", i / 3, i % 3));
    end
  endtask

  task automatic expect_line_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk_74a);
      if (uart_txd !== 1'b1) begin
        $display("UART sent more bytes after the dump at %0t", $time);
        failure_count++;
        break;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one arm, capture and dump round

  task automatic run_trace(input int skip);
    bridge_pkg::trace_status_t got;
    bridge_pkg::trace_status_t want;
    logic [31:0]               wr_value;
    logic [31:0]               rd_value;
    model_q.delete();
    rx_q.delete();
    wr_value       = $random(seed);
    wr_value[15:0] = 16'(skip);
    bridge_write(bridge_pkg::REG_TRACE_CTRL, wr_value);
    bridge_read(bridge_pkg::REG_TRACE_CTRL, rd_value);
    check_rd_data(rd_value, {16'h0000, wr_value[15:0]}, "skip count readback");
    read_status(got);
    want.state = trace_pkg::CAPTURE;
    want.count = '0;
    check_status(got, want, "status after arm");
    fork
      drive_changes(skip + trace_pkg::TRACE_DEPTH + 4, 1'b1, skip);
      receive_dump(trace_pkg::TRACE_DEPTH * trace_pkg::BYTES_PER_ENTRY);
    join
    compare_dump();
    wait_for_state(trace_pkg::DONE);
    read_status(got);
    want.state = trace_pkg::DONE;
    want.count = trace_pkg::trace_count_t'(trace_pkg::TRACE_DEPTH);
    check_status(got, want, "status after dump");
    expect_line_idle(3 * 10 * trace_pkg::CLKS_PER_BIT);
  endtask

  initial begin
    bridge_pkg::trace_status_t got;
    bridge_pkg::trace_status_t want;
    logic [31:0]               addr;
    logic [31:0]               rd_value;
    clk_74a         = 1'b0;
    pll_core_locked = 1'b0;
    bridge          = '0;
    debug_pc        = '0;
    repeat (5) @(posedge clk_74a);
    #2;
    pll_core_locked = 1'b1;

    // idle after reset, program counter changes ignored
    read_status(got);
    want.state = trace_pkg::IDLE;
    want.count = '0;
    check_status(got, want, "status after reset");
    bridge_read(bridge_pkg::REG_TRACE_CTRL, rd_value);
    check_rd_data(rd_value, 32'h0, "skip count after reset");
    drive_changes(6, 1'b0, 0);

    addr = $random(seed);
    if (addr == bridge_pkg::REG_TRACE_CTRL || addr == bridge_pkg::REG_TRACE_STATUS) begin
      addr = addr ^ 32'h8000_0000;
    end
    bridge_read(addr, rd_value);
    check_rd_data(rd_value, 32'h0, "unmapped address");

    run_trace(2 + int'($unsigned($random(seed)) % 9));
    // re-arm from DONE without skipping
    run_trace(0);

    $display("value errors: %0d, other failures: %0d", error_count, failure_count);
    if (error_count == 0 && failure_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
